// ==== fib_settings.svh ====
`ifndef FIB_SETTINGS_SVH
`define FIB_SETTINGS_SVH

// Route entries held by each of the two banks
`define FIB_BANK_ENTRIES 8

// Request queue depth, also the credits a requester starts with
`define FIB_REQ_CREDITS 4

// Result slots downstream grants after reset
`define FIB_RES_CREDITS 4

// Width of an outgoing face number
`define FIB_FACE_BITS 4

`endif

// ==== fib_pkg.sv ====
`include "fib_settings.svh"

package fib_pkg;

    // Bits needed to address one entry inside a bank
    localparam int BANK_IDX_BITS = $clog2(`FIB_BANK_ENTRIES);

    // Name prefix, MSB is the first name bit
    typedef logic [63:0] name_prefix_t;

    // Number of significant leading prefix bits
    typedef logic [5:0] prefix_len_t;

    typedef logic [`FIB_FACE_BITS-1:0] face_t;

    // Table index, top bit picks the bank
    typedef logic [BANK_IDX_BITS:0] fib_index_t;

    typedef struct packed {
        name_prefix_t prefix;
        prefix_len_t  len;
    } lookup_req_t;

    // Best match found inside one bank
    typedef struct packed {
        logic        hit;
        prefix_len_t len;
        face_t       face;
    } bank_match_t;

    // Ones in the leading len bits, zero length gives an empty mask
    function automatic name_prefix_t prefix_mask(prefix_len_t len);
        return ~({64{1'b1}} >> len);
    endfunction

endpackage

// ==== fib_if.sv ====
// Route write or delete, broadcast to both banks
interface fib_update_if
    import fib_pkg::*;
();
    logic         valid;
    fib_index_t   index;
    name_prefix_t prefix;
    prefix_len_t  len;
    face_t        face;
    logic         entry_valid;

    modport src (
        output valid, index, prefix, len, face, entry_valid
    );

    modport bank (
        input valid, index, prefix, len, face, entry_valid
    );
endinterface

// Registered best match of one bank toward the combiner
interface fib_match_if
    import fib_pkg::*;
();
    logic        valid;
    logic        hit;
    prefix_len_t len;
    face_t       face;

    modport bank (
        output valid, hit, len, face
    );

    modport combiner (
        input valid, hit, len, face
    );
endinterface

// ==== fib_req_queue.sv ====
`include "fib_settings.svh"

module fib_req_queue
    import fib_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         req_valid,
    input  name_prefix_t req_prefix,
    input  prefix_len_t  req_len,
    input  logic         issue_ready,
    output logic         req_credit,
    output logic         issue_valid,
    output lookup_req_t  issue_req
);

    localparam int DEPTH = `FIB_REQ_CREDITS;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    lookup_req_t        mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               pop;

    // Head leaves as soon as a result slot is reserved
    assign pop         = (count != '0) && issue_ready;
    assign issue_valid = pop;
    assign issue_req   = mem[rd_ptr];

    // Each issued lookup frees one queue slot for the requester
    assign req_credit  = pop;

    always_ff @(posedge clk) begin
        if (req_valid) begin
            mem[wr_ptr] <= '{prefix: req_prefix, len: req_len};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (req_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (req_valid && !pop) begin
                count <= count + 1'b1;
            end else if (!req_valid && pop) begin
                count <= count - 1'b1;
            end
        end
    end

    // Requester pushed without holding a credit
    a_no_push_when_full: assert property (
        @(posedge clk) disable iff (rst)
        req_valid |-> (count != CNT_W'(DEPTH))
    );

endmodule

// ==== fib_lpm_bank.sv ====
`include "fib_settings.svh"

module fib_lpm_bank
    import fib_pkg::*;
#(
    parameter bit BANK_ID = 1'b0
) (
    input  logic         clk,
    input  logic         rst,
    fib_update_if.bank   upd,
    input  logic         issue_valid,
    input  lookup_req_t  issue_req,
    fib_match_if.bank    match
);

    localparam int ENTRIES = `FIB_BANK_ENTRIES;

    logic         ent_valid  [ENTRIES];
    name_prefix_t ent_prefix [ENTRIES];
    prefix_len_t  ent_len    [ENTRIES];
    face_t        ent_face   [ENTRIES];

    logic               wr_en;
    logic [ENTRIES-1:0] ent_hit;
    bank_match_t        best;

    // Only writes addressed to this bank land here
    assign wr_en = upd.valid && (upd.index[BANK_IDX_BITS] == BANK_ID);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ENTRIES; i++) begin
                ent_valid[i] <= 1'b0;
            end
        end else if (wr_en) begin
            ent_valid[upd.index[BANK_IDX_BITS-1:0]] <= upd.entry_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            ent_prefix[upd.index[BANK_IDX_BITS-1:0]] <= upd.prefix;
            ent_len[upd.index[BANK_IDX_BITS-1:0]]    <= upd.len;
            ent_face[upd.index[BANK_IDX_BITS-1:0]]   <= upd.face;
        end
    end

    // Entry is a candidate when its leading bits agree with the request
    always_comb begin
        for (int i = 0; i < ENTRIES; i++) begin
            ent_hit[i] = ent_valid[i]
                && (ent_len[i] <= issue_req.len)
                && (((ent_prefix[i] ^ issue_req.prefix) & prefix_mask(ent_len[i])) == '0);
        end
    end

    // Strictly longer replaces, so ties stay with the lower index
    always_comb begin
        best = '0;
        for (int i = 0; i < ENTRIES; i++) begin
            if (ent_hit[i] && (!best.hit || (ent_len[i] > best.len))) begin
                best.hit  = 1'b1;
                best.len  = ent_len[i];
                best.face = ent_face[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            match.valid <= 1'b0;
            match.hit   <= 1'b0;
        end else begin
            match.valid <= issue_valid;
            match.hit   <= issue_valid && best.hit;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            match.len  <= best.len;
            match.face <= best.face;
        end
    end

    // A hit belongs to an issued lookup and never outgrows its length
    a_hit_valid_and_fits: assert property (
        @(posedge clk) disable iff (rst)
        match.hit |-> match.valid && (match.len <= $past(issue_req.len))
    );

endmodule

// ==== fib_match_combiner.sv ====
`include "fib_settings.svh"

module fib_match_combiner
    import fib_pkg::*;
(
    input  logic           clk,
    input  logic           rst,
    fib_match_if.combiner  match_a,
    fib_match_if.combiner  match_b,
    input  logic           issue_valid,
    input  lookup_req_t    issue_req,
    input  logic           res_credit,
    output logic           issue_ready,
    output logic           res_valid,
    output logic           res_hit,
    output name_prefix_t   res_prefix,
    output prefix_len_t    res_len,
    output face_t          res_face
);

    localparam int CNT_W = $clog2(`FIB_RES_CREDITS + 1);

    logic [CNT_W-1:0] credit_cnt;
    name_prefix_t     prefix_q;
    bank_match_t      win;

    // Request prefix lines up with the bank matches one cycle later
    always_ff @(posedge clk) begin
        if (issue_valid) begin
            prefix_q <= issue_req.prefix;
        end
    end

    // Bank 1 only wins when strictly longer
    always_comb begin
        if (match_b.hit && (!match_a.hit || (match_b.len > match_a.len))) begin
            win = '{hit: 1'b1, len: match_b.len, face: match_b.face};
        end else if (match_a.hit) begin
            win = '{hit: 1'b1, len: match_a.len, face: match_a.face};
        end else begin
            win = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid <= 1'b0;
            res_hit   <= 1'b0;
        end else begin
            res_valid <= match_a.valid;
            res_hit   <= match_a.valid && win.hit;
        end
    end

    // Misses leave all payload fields at zero
    always_ff @(posedge clk) begin
        if (match_a.valid) begin
            res_prefix <= win.hit ? (prefix_q & prefix_mask(win.len)) : '0;
            res_len    <= win.len;
            res_face   <= win.face;
        end
    end

    // One slot reserved per issue, one returned per res_credit
    always_ff @(posedge clk) begin
        if (rst) begin
            credit_cnt <= CNT_W'(`FIB_RES_CREDITS);
        end else if (issue_valid && !res_credit) begin
            credit_cnt <= credit_cnt - 1'b1;
        end else if (!issue_valid && res_credit) begin
            credit_cnt <= credit_cnt + 1'b1;
        end
    end

    assign issue_ready = (credit_cnt != '0);

    a_credit_bound: assert property (
        @(posedge clk) disable iff (rst)
        credit_cnt <= CNT_W'(`FIB_RES_CREDITS)
    );

    // Both banks see every issue, so their matches arrive together
    a_banks_aligned: assert property (
        @(posedge clk) disable iff (rst)
        match_a.valid == match_b.valid
    );

endmodule

// ==== fib_top.sv ====
module fib_top
    import fib_pkg::*;
(
    input  logic         clk,
    input  logic         rst,

    // Lookup requests
    input  logic         req_valid,
    input  name_prefix_t req_prefix,
    input  prefix_len_t  req_len,
    output logic         req_credit,

    // Route writes and deletes
    input  logic         upd_valid,
    input  fib_index_t   upd_index,
    input  name_prefix_t upd_prefix,
    input  prefix_len_t  upd_len,
    input  face_t        upd_face,
    input  logic         upd_entry_valid,

    // Lookup results
    output logic         res_valid,
    output logic         res_hit,
    output name_prefix_t res_prefix,
    output prefix_len_t  res_len,
    output face_t        res_face,
    input  logic         res_credit
);

    logic        issue_valid;
    logic        issue_ready;
    lookup_req_t issue_req;

    fib_update_if upd_if ();
    fib_match_if  match0_if ();
    fib_match_if  match1_if ();

    assign upd_if.valid       = upd_valid;
    assign upd_if.index       = upd_index;
    assign upd_if.prefix      = upd_prefix;
    assign upd_if.len         = upd_len;
    assign upd_if.face        = upd_face;
    assign upd_if.entry_valid = upd_entry_valid;

    fib_req_queue queue_i (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req_prefix  (req_prefix),
        .req_len     (req_len),
        .issue_ready (issue_ready),
        .req_credit  (req_credit),
        .issue_valid (issue_valid),
        .issue_req   (issue_req)
    );

    fib_lpm_bank #(.BANK_ID(1'b0)) bank0_i (
        .clk         (clk),
        .rst         (rst),
        .upd         (upd_if.bank),
        .issue_valid (issue_valid),
        .issue_req   (issue_req),
        .match       (match0_if.bank)
    );

    fib_lpm_bank #(.BANK_ID(1'b1)) bank1_i (
        .clk         (clk),
        .rst         (rst),
        .upd         (upd_if.bank),
        .issue_valid (issue_valid),
        .issue_req   (issue_req),
        .match       (match1_if.bank)
    );

    fib_match_combiner combiner_i (
        .clk         (clk),
        .rst         (rst),
        .match_a     (match0_if.combiner),
        .match_b     (match1_if.combiner),
        .issue_valid (issue_valid),
        .issue_req   (issue_req),
        .res_credit  (res_credit),
        .issue_ready (issue_ready),
        .res_valid   (res_valid),
        .res_hit     (res_hit),
        .res_prefix  (res_prefix),
        .res_len     (res_len),
        .res_face    (res_face)
    );

endmodule

// ==== fib_tb.sv ====
`include "fib_settings.svh"

module fib_tb
    import fib_pkg::*;
();

    localparam int N_EMPTY   = 20;
    localparam int N_RANDOM  = 300;
    localparam int N_EDITED  = 100;
    localparam int N_SLOW    = 60;
    localparam int N_WRITES  = 16 + 8;
    localparam int N_LOOKUPS = N_EMPTY + N_RANDOM + N_EDITED + N_SLOW + 1;

    typedef struct packed {
        logic         hit;
        name_prefix_t prefix;
        prefix_len_t  len;
        face_t        face;
    } expected_t;

    logic         clk;
    logic         rst;
    logic         req_valid;
    name_prefix_t req_prefix;
    prefix_len_t  req_len;
    logic         req_credit;
    logic         upd_valid;
    fib_index_t   upd_index;
    name_prefix_t upd_prefix;
    prefix_len_t  upd_len;
    face_t        upd_face;
    logic         upd_entry_valid;
    logic         res_valid;
    logic         res_hit;
    name_prefix_t res_prefix;
    prefix_len_t  res_len;
    face_t        res_face;
    logic         res_credit;

    // Reference copy of the whole table, index 8 and up is bank 1
    logic         m_valid [16];
    name_prefix_t m_prefix [16];
    prefix_len_t  m_len [16];
    face_t        m_face [16];

    expected_t exp_q [$];
    int        credit_due [$];
    int        cycle = 0;
    int        req_credits = `FIB_REQ_CREDITS;
    int        reqs_sent = 0;
    int        credit_pulses = 0;
    int        results = 0;
    int        credits_returned = 0;
    int        delay_max = 6;
    int        last_req_cycle = 0;
    int        last_res_cycle = 0;
    int        value_errors = 0;
    int        proto_errors = 0;

    fib_top dut_i (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle++;
    end

    function automatic name_prefix_t keep_leading(input name_prefix_t p, input int n);
        name_prefix_t r;
        r = '0;
        for (int b = 0; b < n; b++) begin
            r[63-b] = p[63-b];
        end
        return r;
    endfunction

    // Longest match wins, ties stay with the lowest table index
    function automatic expected_t model_lookup(input name_prefix_t p, input prefix_len_t l);
        expected_t e;
        e = '0;
        for (int i = 0; i < 16; i++) begin
            if (m_valid[i] && (m_len[i] <= l)
                    && (keep_leading(m_prefix[i], m_len[i]) == keep_leading(p, m_len[i]))) begin
                if (!e.hit || (m_len[i] > e.len)) begin
                    e.hit  = 1'b1;
                    e.len  = m_len[i];
                    e.face = m_face[i];
                end
            end
        end
        if (e.hit) begin
            e.prefix = keep_leading(p, e.len);
        end
        return e;
    endfunction

    task automatic report_field(input string field, input logic [63:0] got,
                                input logic [63:0] want);
        value_errors++;
        $display("[ERROR] %0t: %s got %h expected %h", $time, field, got, want);
    endtask

    // Outputs are sampled mid-cycle, well away from the driving edge
    always @(negedge clk) begin
        expected_t e;
        if (!rst && req_credit) begin
            credit_pulses++;
            req_credits++;
            if (credit_pulses > reqs_sent) begin
                proto_errors++;
                $display("[ERROR] %0t: more request credits returned than lookups sent", $time);
            end
        end
        if (!rst && res_valid) begin
            results++;
            last_res_cycle = cycle;
            if (results > `FIB_RES_CREDITS + credits_returned) begin
                proto_errors++;
                $display("[ERROR] %0t: result sent without a result credit", $time);
            end
            if (exp_q.size() == 0) begin
                proto_errors++;
                $display("[ERROR] %0t: result arrived with no lookup outstanding", $time);
            end else begin
                e = exp_q.pop_front();
                if (res_hit !== e.hit) report_field("res_hit", 64'(res_hit), 64'(e.hit));
                if (res_prefix !== e.prefix) report_field("res_prefix", res_prefix, e.prefix);
                if (res_len !== e.len) report_field("res_len", 64'(res_len), 64'(e.len));
                if (res_face !== e.face) report_field("res_face", 64'(res_face), 64'(e.face));
            end
            credit_due.push_back(cycle + $urandom_range(0, delay_max));
        end
    end

    // Downstream hands each consumed result slot back after its delay
    always @(posedge clk) begin
        #1;
        res_credit = 1'b0;
        if (!rst && (credit_due.size() > 0) && (credit_due[0] <= cycle)) begin
            void'(credit_due.pop_front());
            res_credit = 1'b1;
            credits_returned++;
        end
    end

    task automatic write_entry(input int idx, input name_prefix_t p, input prefix_len_t l,
                               input face_t f, input logic v);
        @(posedge clk);
        #1;
        upd_valid       = 1'b1;
        upd_index       = fib_index_t'(idx);
        upd_prefix      = p;
        upd_len         = l;
        upd_face        = f;
        upd_entry_valid = v;
        m_valid[idx]    = v;
        m_prefix[idx]   = p;
        m_len[idx]      = l;
        m_face[idx]     = f;
        @(posedge clk);
        #1;
        upd_valid = 1'b0;
    endtask

    task automatic random_entry(input int idx);
        int           src;
        name_prefix_t p;
        prefix_len_t  l;
        src = $urandom_range(0, 15);
        p = {$urandom, $urandom};
        l = prefix_len_t'($urandom_range(1, 63));
        // Shared prefixes give nested routes and length ties
        if (m_valid[src] && ($urandom_range(0, 1) == 1)) begin
            p = m_prefix[src];
            if ($urandom_range(0, 1) == 1) begin
                l = m_len[src];
            end
        end
        if ($urandom_range(0, 5) == 0) begin
            l = '0;
        end
        write_entry(idx, p, l, face_t'($urandom), 1'b1);
    endtask

    task automatic send_lookup(input name_prefix_t p, input prefix_len_t l);
        @(posedge clk);
        #1;
        while (req_credits == 0) begin
            req_valid = 1'b0;
            @(posedge clk);
            #1;
        end
        req_valid  = 1'b1;
        req_prefix = p;
        req_len    = l;
        req_credits--;
        reqs_sent++;
        last_req_cycle = cycle;
        exp_q.push_back(model_lookup(p, l));
    endtask

    task automatic random_lookup();
        int           k;
        name_prefix_t p;
        prefix_len_t  l;
        k = $urandom_range(0, 15);
        p = {$urandom, $urandom};
        l = prefix_len_t'($urandom_range(0, 63));
        if (m_valid[k] && ($urandom_range(0, 3) != 0)) begin
            l = prefix_len_t'($urandom_range(m_len[k], 63));
            p = keep_leading(m_prefix[k], m_len[k]) | (p & ~keep_leading('1, m_len[k]));
        end
        send_lookup(p, l);
    endtask

    // Stop requesting and wait until every result and credit is back
    task automatic drain();
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        while ((exp_q.size() > 0) || (credit_due.size() > 0)) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);
        #1;
    endtask

    initial begin
        #((N_WRITES + 8 * N_LOOKUPS + 200) * 4);
        $display("Timeout: the run did not finish in time, %0d results still pending",
                 exp_q.size());
        $display("Finished with errors");
        $finish;
    end

    initial begin
        void'($urandom(32'h5265b64d));
        clk = 1'b0;
        rst = 1'b1;
        req_valid = 1'b0;
        req_prefix = '0;
        req_len = '0;
        upd_valid = 1'b0;
        upd_index = '0;
        upd_prefix = '0;
        upd_len = '0;
        upd_face = '0;
        upd_entry_valid = 1'b0;
        res_credit = 1'b0;
        for (int i = 0; i < 16; i++) begin
            m_valid[i] = 1'b0;
        end
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        repeat (N_EMPTY) random_lookup();
        drain();

        for (int i = 0; i < 16; i++) begin
            random_entry(i);
        end
        repeat (N_RANDOM) random_lookup();
        drain();

        // Deletes and rewrites between lookup phases
        for (int i = 0; i < 8; i++) begin
            if ($urandom_range(0, 1) == 1) begin
                write_entry($urandom_range(0, 15), '0, '0, '0, 1'b0);
            end else begin
                random_entry($urandom_range(0, 15));
            end
        end
        repeat (N_EDITED) random_lookup();
        drain();

        delay_max = 24;
        repeat (N_SLOW) random_lookup();
        drain();
        delay_max = 6;

        // Idle FIB with full credits answers in a fixed number of cycles
        random_lookup();
        drain();
        if (last_res_cycle - last_req_cycle != 3) begin
            proto_errors++;
            $display("[ERROR] %0t: lookup latency %0d cycles, expected 3", $time,
                     last_res_cycle - last_req_cycle);
        end

        $display("Lookups %0d, results %0d, value errors %0d, credit and timing errors %0d",
                 reqs_sent, results, value_errors, proto_errors);
        if ((value_errors == 0) && (proto_errors == 0) && (results == N_LOOKUPS)) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+.
fib_pkg.sv
fib_if.sv
fib_req_queue.sv
fib_lpm_bank.sv
fib_match_combiner.sv
fib_top.sv
fib_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the FIB testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module fib_tb -f list.f -o fib_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/fib_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Finished with errors" sim.log; then
    exit 1
fi
exit 0
